/* design/mem_noc_pkg.sv */
/* Memory NoC package.
   Widths, memory message, wormhole payload, packet and link types. */

package mem_noc_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int CORD_WIDTH = 4;
   localparam int DID_WIDTH  = 2;
   localparam int LEN_WIDTH  = 3;   // Flits following the header.
   localparam int ADDR_WIDTH = 16;
   localparam int DATA_WIDTH = 32;
   localparam int FLIT_WIDTH = 16;  // Default link width.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Memory message
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic {
      e_mem_rd = 1'b0,
      e_mem_wr = 1'b1
   } mem_op_e;

   typedef struct packed {
      mem_op_e               op;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
   } mem_msg_s;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wormhole packet and link
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef struct packed {
      logic [DID_WIDTH-1:0]  src_did;   // Where the response goes back to.
      logic [CORD_WIDTH-1:0] src_cord;
      mem_msg_s              msg;
   } mem_payload_s;

   // Fields listed MSB first, so cord lands in the header flit.
   typedef struct packed {
      mem_payload_s          payload;
      logic [DID_WIDTH-1:0]  did;
      logic [LEN_WIDTH-1:0]  len;
      logic [CORD_WIDTH-1:0] cord;
   } mem_packet_s;

   typedef struct packed {
      logic                  v;
      logic [FLIT_WIDTH-1:0] data;
      logic                  ready_and;
   } link_s;

endpackage

/* design/mem_packet_encode.sv */
/* Wormhole packet encoder.
   Wraps a memory message with source fields and a routing header. */

`timescale 1ns/1ps

module mem_packet_encode #(
   parameter int FLIT_WIDTH = mem_noc_pkg::FLIT_WIDTH
) (
   input  mem_noc_pkg::mem_msg_s                    msg_i,
   input  logic [mem_noc_pkg::DID_WIDTH-1:0]        src_did_i,
   input  logic [mem_noc_pkg::CORD_WIDTH-1:0]       src_cord_i,
   input  logic [mem_noc_pkg::DID_WIDTH-1:0]        dst_did_i,
   input  logic [mem_noc_pkg::CORD_WIDTH-1:0]       dst_cord_i,
   output mem_noc_pkg::mem_packet_s                 packet_o
);

   localparam int PACKET_WIDTH = $bits(mem_noc_pkg::mem_packet_s);
   localparam int FLIT_COUNT   = (PACKET_WIDTH + FLIT_WIDTH - 1) / FLIT_WIDTH;
   localparam logic [mem_noc_pkg::LEN_WIDTH-1:0] PACKET_LEN =
      mem_noc_pkg::LEN_WIDTH'(FLIT_COUNT - 1);

   always_comb begin
      packet_o.cord             = dst_cord_i;
      packet_o.len              = PACKET_LEN;  // Header flit not counted.
      packet_o.did              = dst_did_i;
      packet_o.payload.src_did  = src_did_i;
      packet_o.payload.src_cord = src_cord_i;
      packet_o.payload.msg      = msg_i;
   end

endmodule

/* design/wormhole_adapter_in.sv */
/* Wormhole adapter, packet to link.
   Loads one packet and sends it out as header-first flits. */

`timescale 1ns/1ps

module wormhole_adapter_in #(
   parameter type packet_t   = mem_noc_pkg::mem_packet_s,
   parameter int  FLIT_WIDTH = mem_noc_pkg::FLIT_WIDTH
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  packet_t             packet_i,
   input  logic                v_i,
   output logic                ready_o,

   input  mem_noc_pkg::link_s  link_i,
   output mem_noc_pkg::link_s  link_o
);

   localparam int PACKET_WIDTH = $bits(packet_t);
   localparam int FLIT_COUNT   = (PACKET_WIDTH + FLIT_WIDTH - 1) / FLIT_WIDTH;
   localparam int BUF_WIDTH    = FLIT_COUNT * FLIT_WIDTH;

   logic [BUF_WIDTH-1:0]                shift_r;
   logic [mem_noc_pkg::LEN_WIDTH-1:0]   cnt_r;
   logic                                busy_r;
   logic                                accept;
   logic                                flit_sent;

   assign ready_o   = ~busy_r;
   assign accept    = v_i & ready_o;
   assign flit_sent = busy_r & link_i.ready_and;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Flit counter
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_r <= 1'b0;
         cnt_r  <= '0;
      end else if (accept) begin
         busy_r <= 1'b1;
         cnt_r  <= packet_i.len;       // Flits left after the header.
      end else if (flit_sent) begin
         if (cnt_r == '0) begin
            busy_r <= 1'b0;            // Last flit gone.
         end else begin
            cnt_r <= cnt_r - 1'b1;
         end
      end
   end

   // Packet data; low flit is always the one on the link.
   always_ff @(posedge clk_i) begin
      if (accept) begin
         shift_r <= BUF_WIDTH'(packet_i);
      end else if (flit_sent) begin
         shift_r <= shift_r >> FLIT_WIDTH;
      end
   end

   // Sender side only, so the ready_and slot of this link stays low.
   assign link_o.v         = busy_r;
   assign link_o.data      = shift_r[FLIT_WIDTH-1:0];
   assign link_o.ready_and = 1'b0;

endmodule

/* design/wormhole_adapter_out.sv */
/* Wormhole adapter, link to packet.
   Collects flits into a packet and holds it until yumi. */

`timescale 1ns/1ps

module wormhole_adapter_out #(
   parameter type packet_t   = mem_noc_pkg::mem_packet_s,
   parameter int  FLIT_WIDTH = mem_noc_pkg::FLIT_WIDTH
) (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  mem_noc_pkg::link_s  link_i,
   output mem_noc_pkg::link_s  link_o,

   output packet_t             packet_o,
   output logic                v_o,
   input  logic                yumi_i
);

   localparam int PACKET_WIDTH = $bits(packet_t);
   localparam int FLIT_COUNT   = (PACKET_WIDTH + FLIT_WIDTH - 1) / FLIT_WIDTH;
   localparam int BUF_WIDTH    = FLIT_COUNT * FLIT_WIDTH;

   logic [BUF_WIDTH-1:0]                buf_r;
   logic [mem_noc_pkg::LEN_WIDTH-1:0]   idx_r;
   logic [mem_noc_pkg::LEN_WIDTH-1:0]   len_r;
   logic [mem_noc_pkg::LEN_WIDTH-1:0]   hdr_len;
   logic                                full_r;
   logic                                take;
   logic                                last;

   assign take    = link_i.v & ~full_r;
   assign hdr_len = link_i.data[mem_noc_pkg::CORD_WIDTH +: mem_noc_pkg::LEN_WIDTH];

   always_comb begin
      if (idx_r == '0) begin
         last = (hdr_len == '0);       // Header-only packet.
      end else begin
         last = (idx_r == len_r);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Fill and hold control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         full_r <= 1'b0;
         idx_r  <= '0;
         len_r  <= '0;
      end else if (take) begin
         if (idx_r == '0) begin
            len_r <= hdr_len;
         end
         if (last) begin
            idx_r  <= '0;
            full_r <= 1'b1;
         end else begin
            idx_r <= idx_r + 1'b1;
         end
      end else if (full_r && yumi_i) begin
         full_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         buf_r[idx_r*FLIT_WIDTH +: FLIT_WIDTH] <= link_i.data;
      end
   end

   assign packet_o = packet_t'(buf_r[PACKET_WIDTH-1:0]);
   assign v_o      = full_r;

   // Receiver side only; flow control stops while a packet is held.
   assign link_o.v         = 1'b0;
   assign link_o.data      = '0;
   assign link_o.ready_and = ~full_r;

endmodule

/* design/mem_link_master.sv */
/* Memory link master.
   Sends engine commands as wormhole packets and returns the responses. */

`timescale 1ns/1ps

module mem_link_master #(
   parameter int FLIT_WIDTH = mem_noc_pkg::FLIT_WIDTH
) (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,

   input  mem_noc_pkg::mem_msg_s                 mem_cmd_i,
   input  logic                                  mem_cmd_v_i,
   output logic                                  mem_cmd_ready_o,

   output mem_noc_pkg::mem_msg_s                 mem_resp_o,
   output logic                                  mem_resp_v_o,
   input  logic                                  mem_resp_yumi_i,

   input  logic [mem_noc_pkg::DID_WIDTH-1:0]     my_did_i,
   input  logic [mem_noc_pkg::CORD_WIDTH-1:0]    my_cord_i,
   input  logic [mem_noc_pkg::DID_WIDTH-1:0]     dst_did_i,
   input  logic [mem_noc_pkg::CORD_WIDTH-1:0]    dst_cord_i,

   input  mem_noc_pkg::link_s                    cmd_link_i,
   output mem_noc_pkg::link_s                    cmd_link_o,
   input  mem_noc_pkg::link_s                    resp_link_i,
   output mem_noc_pkg::link_s                    resp_link_o
);

   mem_noc_pkg::mem_packet_s cmd_packet;
   mem_noc_pkg::mem_packet_s resp_packet;

   mem_packet_encode #(.FLIT_WIDTH(FLIT_WIDTH)) cmd_encode (
      .msg_i      (mem_cmd_i),
      .src_did_i  (my_did_i),
      .src_cord_i (my_cord_i),
      .dst_did_i  (dst_did_i),
      .dst_cord_i (dst_cord_i),
      .packet_o   (cmd_packet)
   );

   wormhole_adapter_in #(
      .packet_t   (mem_noc_pkg::mem_packet_s),
      .FLIT_WIDTH (FLIT_WIDTH)
   ) cmd_adapter_in (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .packet_i (cmd_packet),
      .v_i      (mem_cmd_v_i),
      .ready_o  (mem_cmd_ready_o),
      .link_i   (cmd_link_i),
      .link_o   (cmd_link_o)
   );

   wormhole_adapter_out #(
      .packet_t   (mem_noc_pkg::mem_packet_s),
      .FLIT_WIDTH (FLIT_WIDTH)
   ) resp_adapter_out (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .link_i   (resp_link_i),
      .link_o   (resp_link_o),
      .packet_o (resp_packet),
      .v_o      (mem_resp_v_o),
      .yumi_i   (mem_resp_yumi_i)
   );

   assign mem_resp_o = resp_packet.payload.msg;  // Routing fields dropped here.

endmodule

/* design/mem_word_store.sv */
/* Word store.
   Small register array, one read or write per request, cleared at reset. */

`timescale 1ns/1ps

module mem_word_store #(
   parameter int DEPTH = 16
) (
   input  logic                                clk_i,
   input  logic                                rst_n_i,

   input  logic                                v_i,
   input  mem_noc_pkg::mem_op_e                op_i,
   input  logic [mem_noc_pkg::ADDR_WIDTH-1:0]  addr_i,
   input  logic [mem_noc_pkg::DATA_WIDTH-1:0]  wdata_i,
   output logic [mem_noc_pkg::DATA_WIDTH-1:0]  rdata_o
);

   localparam int IDX_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [mem_noc_pkg::DATA_WIDTH-1:0] mem_r [DEPTH];
   logic [mem_noc_pkg::DATA_WIDTH-1:0] rdata_r;
   logic [IDX_WIDTH-1:0]               idx;
   logic                               wr;

   assign idx = addr_i[IDX_WIDTH-1:0];  // Upper address bits alias.
   assign wr  = v_i && (op_i == mem_noc_pkg::e_mem_wr);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem_r[i] <= '0;
         end
      end else if (wr) begin
         mem_r[idx] <= wdata_i;
      end
   end

   // A write echoes the stored word.
   always_ff @(posedge clk_i) begin
      if (v_i) begin
         rdata_r <= wr ? wdata_i : mem_r[idx];
      end
   end

   assign rdata_o = rdata_r;

endmodule

/* design/mem_link_client.sv */
/* Memory link client.
   Decodes command packets, accesses the word store and returns responses. */

`timescale 1ns/1ps

module mem_link_client #(
   parameter int FLIT_WIDTH = mem_noc_pkg::FLIT_WIDTH,
   parameter int DEPTH      = 16
) (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,

   input  mem_noc_pkg::link_s                    cmd_link_i,
   output mem_noc_pkg::link_s                    cmd_link_o,
   input  mem_noc_pkg::link_s                    resp_link_i,
   output mem_noc_pkg::link_s                    resp_link_o,

   input  logic [mem_noc_pkg::DID_WIDTH-1:0]     my_did_i,
   input  logic [mem_noc_pkg::CORD_WIDTH-1:0]    my_cord_i
);

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      SEND
   } state_e;

   state_e                               state_r;
   mem_noc_pkg::mem_packet_s             cmd_packet;
   mem_noc_pkg::mem_packet_s             resp_packet;
   mem_noc_pkg::mem_msg_s                resp_msg;
   logic [mem_noc_pkg::DATA_WIDTH-1:0]   rdata;
   logic                                 cmd_v;
   logic                                 cmd_yumi;
   logic                                 resp_v;
   logic                                 resp_ready;

   wormhole_adapter_out #(
      .packet_t   (mem_noc_pkg::mem_packet_s),
      .FLIT_WIDTH (FLIT_WIDTH)
   ) cmd_adapter_out (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .link_i   (cmd_link_i),
      .link_o   (cmd_link_o),
      .packet_o (cmd_packet),
      .v_o      (cmd_v),
      .yumi_i   (cmd_yumi)
   );

   mem_word_store #(.DEPTH(DEPTH)) store (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (state_r == ACCESS),
      .op_i    (cmd_packet.payload.msg.op),
      .addr_i  (cmd_packet.payload.msg.addr),
      .wdata_i (cmd_packet.payload.msg.data),
      .rdata_o (rdata)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Command to response FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_r <= IDLE;
      end else begin
         case (state_r)
            IDLE:    if (cmd_v) state_r <= ACCESS;
            ACCESS:  state_r <= SEND;               // Store data is ready next.
            SEND:    if (resp_ready) state_r <= IDLE;
            default: state_r <= IDLE;
         endcase
      end
   end

   // Command stays in the adapter until its response is taken.
   assign resp_v   = (state_r == SEND);
   assign cmd_yumi = resp_v & resp_ready;

   always_comb begin
      resp_msg      = cmd_packet.payload.msg;
      resp_msg.data = rdata;
   end

   mem_packet_encode #(.FLIT_WIDTH(FLIT_WIDTH)) resp_encode (
      .msg_i      (resp_msg),
      .src_did_i  (my_did_i),
      .src_cord_i (my_cord_i),
      .dst_did_i  (cmd_packet.payload.src_did),
      .dst_cord_i (cmd_packet.payload.src_cord),
      .packet_o   (resp_packet)
   );

   wormhole_adapter_in #(
      .packet_t   (mem_noc_pkg::mem_packet_s),
      .FLIT_WIDTH (FLIT_WIDTH)
   ) resp_adapter_in (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .packet_i (resp_packet),
      .v_i      (resp_v),
      .ready_o  (resp_ready),
      .link_i   (resp_link_i),
      .link_o   (resp_link_o)
   );

endmodule

/* design/mem_link_top.sv */
/* Memory link top level.
   Link master and memory client joined by point-to-point command and response links. */

`timescale 1ns/1ps

module mem_link_top #(
   parameter int FLIT_WIDTH  = mem_noc_pkg::FLIT_WIDTH,
   parameter int STORE_DEPTH = 16
) (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,

   input  mem_noc_pkg::mem_msg_s                 mem_cmd_i,
   input  logic                                  mem_cmd_v_i,
   output logic                                  mem_cmd_ready_o,

   output mem_noc_pkg::mem_msg_s                 mem_resp_o,
   output logic                                  mem_resp_v_o,
   input  logic                                  mem_resp_yumi_i,

   input  logic [mem_noc_pkg::DID_WIDTH-1:0]     my_did_i,
   input  logic [mem_noc_pkg::DID_WIDTH-1:0]     dst_did_i,
   input  logic [mem_noc_pkg::CORD_WIDTH-1:0]    my_cord_i,
   input  logic [mem_noc_pkg::CORD_WIDTH-1:0]    dst_cord_i
);

   mem_noc_pkg::link_s cmd_m2c;   // Command flits.
   mem_noc_pkg::link_s cmd_c2m;   // Command flow control.
   mem_noc_pkg::link_s resp_c2m;  // Response flits.
   mem_noc_pkg::link_s resp_m2c;  // Response flow control.

   mem_link_master #(.FLIT_WIDTH(FLIT_WIDTH)) master (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .mem_cmd_i       (mem_cmd_i),
      .mem_cmd_v_i     (mem_cmd_v_i),
      .mem_cmd_ready_o (mem_cmd_ready_o),
      .mem_resp_o      (mem_resp_o),
      .mem_resp_v_o    (mem_resp_v_o),
      .mem_resp_yumi_i (mem_resp_yumi_i),
      .my_did_i        (my_did_i),
      .my_cord_i       (my_cord_i),
      .dst_did_i       (dst_did_i),
      .dst_cord_i      (dst_cord_i),
      .cmd_link_i      (cmd_c2m),
      .cmd_link_o      (cmd_m2c),
      .resp_link_i     (resp_c2m),
      .resp_link_o     (resp_m2c)
   );

   mem_link_client #(
      .FLIT_WIDTH (FLIT_WIDTH),
      .DEPTH      (STORE_DEPTH)
   ) client (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_link_i  (cmd_m2c),
      .cmd_link_o  (cmd_c2m),
      .resp_link_i (resp_m2c),
      .resp_link_o (resp_c2m),
      .my_did_i    (dst_did_i),
      .my_cord_i   (dst_cord_i)
   );

endmodule

/* tests/mem_link_tb.sv */
/* Memory link testbench.
   Directed reads, writes, aliasing, back-pressure and a random mix,
   checked against a word-array reference model. */

`timescale 1ns/1ps

module mem_link_tb;

   localparam int FLIT_WIDTH      = 16;
   localparam int STORE_DEPTH     = 16;
   localparam int TXN_CYCLES      = 40;   // Bound for one command and its response.
   localparam int NUM_TXN         = 240;
   localparam int WATCHDOG_CYCLES = NUM_TXN * TXN_CYCLES + 1000;

   logic                                     clk;
   logic                                     rst_n;
   mem_noc_pkg::mem_msg_s                    cmd_data;
   logic                                     cmd_v;
   logic                                     cmd_ready;
   mem_noc_pkg::mem_msg_s                    resp;
   logic                                     resp_v;
   logic                                     resp_yumi;
   logic [mem_noc_pkg::DID_WIDTH-1:0]        my_did;
   logic [mem_noc_pkg::DID_WIDTH-1:0]        dst_did;
   logic [mem_noc_pkg::CORD_WIDTH-1:0]       my_cord;
   logic [mem_noc_pkg::CORD_WIDTH-1:0]       dst_cord;

   logic [mem_noc_pkg::DATA_WIDTH-1:0]       model_mem [STORE_DEPTH];
   mem_noc_pkg::mem_msg_s                    exp_q [$];   // Responses still owed in command order.
   int                                       errors;

   mem_link_top #(
      .FLIT_WIDTH  (FLIT_WIDTH),
      .STORE_DEPTH (STORE_DEPTH)
   ) mem_link_top_i (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .mem_cmd_i       (cmd_data),
      .mem_cmd_v_i     (cmd_v),
      .mem_cmd_ready_o (cmd_ready),
      .mem_resp_o      (resp),
      .mem_resp_v_o    (resp_v),
      .mem_resp_yumi_i (resp_yumi),
      .my_did_i        (my_did),
      .dst_did_i       (dst_did),
      .my_cord_i       (my_cord),
      .dst_cord_i      (dst_cord)
   );

   always #5 clk = ~clk;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model and handshake helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic model_access(input mem_noc_pkg::mem_msg_s cmd,
                               output mem_noc_pkg::mem_msg_s exp);
      int idx;
      idx = int'(cmd.addr) % STORE_DEPTH;   // Addresses alias modulo the depth.
      exp = cmd;
      if (cmd.op == mem_noc_pkg::e_mem_wr) begin
         model_mem[idx] = cmd.data;          // A write echoes its own word.
      end else begin
         exp.data = model_mem[idx];
      end
   endtask

   // All helpers start and end 1 ns after a rising edge.
   task automatic issue_cmd(input mem_noc_pkg::mem_msg_s cmd, input int max_wait,
                            output bit accepted);
      mem_noc_pkg::mem_msg_s exp;
      int                    waited;
      bit                    done;
      waited   = 0;
      done     = 1'b0;
      accepted = 1'b0;
      cmd_data = cmd;
      cmd_v    = 1'b1;
      while (!done) begin
         if (cmd_ready) begin
            @(posedge clk);
            #1;
            accepted = 1'b1;
            done     = 1'b1;
         end else if (waited >= max_wait) begin
            done = 1'b1;
         end else begin
            @(posedge clk);
            #1;
            waited++;
         end
      end
      cmd_v = 1'b0;
      if (accepted) begin
         model_access(cmd, exp);
         exp_q.push_back(exp);
      end
   endtask

   task automatic send_cmd(input mem_noc_pkg::mem_msg_s cmd);
      bit ok;
      issue_cmd(cmd, TXN_CYCLES, ok);
      assert (ok) else begin
         $display("At %0t the command to address %h was not accepted in time", $time, cmd.addr);
         errors++;
      end
   endtask

   task automatic wait_response(output bit seen);
      int waited;
      waited = 0;
      while (!resp_v && waited < TXN_CYCLES) begin
         @(posedge clk);
         #1;
         waited++;
      end
      seen = resp_v;
      assert (seen) else begin
         $display("At %0t no response arrived in time", $time);
         errors++;
      end
   endtask

   task automatic compare_msg(input mem_noc_pkg::mem_msg_s got,
                              input mem_noc_pkg::mem_msg_s exp);
      assert (got.op == exp.op) else begin
         $display("[FAIL] %0t mem_resp_o.op got %0d expected %0d", $time, got.op, exp.op);
         errors++;
      end
      assert (got.addr == exp.addr) else begin
         $display("[FAIL] %0t mem_resp_o.addr got %h expected %h", $time, got.addr, exp.addr);
         errors++;
      end
      assert (got.data == exp.data) else begin
         $display("[FAIL] %0t mem_resp_o.data got %h expected %h", $time, got.data, exp.data);
         errors++;
      end
   endtask

   // The response must stay valid and unchanged while yumi is low.
   task automatic hold_check(input int cycles);
      mem_noc_pkg::mem_msg_s held;
      held = resp;
      repeat (cycles) begin
         @(posedge clk);
         #1;
         assert (resp_v) else begin
            $display("[FAIL] %0t mem_resp_v_o got %b expected 1", $time, resp_v);
            errors++;
         end
         assert (resp == held) else begin
            $display("[FAIL] %0t mem_resp_o got %h expected %h", $time, resp, held);
            errors++;
         end
      end
   endtask

   task automatic take_response(input int delay);
      mem_noc_pkg::mem_msg_s exp;
      bit                    seen;
      wait_response(seen);
      if (seen) begin
         assert (exp_q.size() > 0) else begin
            $display("At %0t a response arrived with no command pending", $time);
            errors++;
         end
         if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            compare_msg(resp, exp);
         end
         hold_check(delay);
         resp_yumi = 1'b1;
         @(posedge clk);
         #1;
         resp_yumi = 1'b0;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic read_after_reset();
      mem_noc_pkg::mem_msg_s cmd;
      for (int i = 0; i < 4; i++) begin
         cmd.op   = mem_noc_pkg::e_mem_rd;
         cmd.addr = 16'(i * 5 + 1);
         cmd.data = $urandom;               // Ignored by a read.
         send_cmd(cmd);
         take_response(0);
      end
   endtask

   task automatic write_then_read();
      mem_noc_pkg::mem_msg_s cmd;
      logic [15:0]           addrs [3];
      addrs[0] = 16'h0003;
      addrs[1] = 16'h0007;
      addrs[2] = 16'h000c;
      for (int i = 0; i < 3; i++) begin
         cmd.op   = mem_noc_pkg::e_mem_wr;
         cmd.addr = addrs[i];
         cmd.data = $urandom;
         send_cmd(cmd);
         take_response(1);
      end
      for (int i = 0; i < 3; i++) begin
         cmd.op   = mem_noc_pkg::e_mem_rd;
         cmd.addr = addrs[i];
         send_cmd(cmd);
         take_response(0);
      end
   endtask

   task automatic address_aliasing();
      mem_noc_pkg::mem_msg_s cmd;
      for (int i = 0; i < 3; i++) begin
         cmd.op   = mem_noc_pkg::e_mem_wr;
         cmd.addr = 16'(i * 6 + 2);
         cmd.data = $urandom;
         send_cmd(cmd);
         take_response(0);
         cmd.op   = mem_noc_pkg::e_mem_rd;
         cmd.addr = cmd.addr + 16'(STORE_DEPTH);
         send_cmd(cmd);
         take_response(0);
      end
   endtask

   task automatic response_backpressure();
      mem_noc_pkg::mem_msg_s cmd;
      bit                    ok;
      bit                    stalled;
      bit                    seen;
      int                    issued;
      stalled   = 1'b0;
      issued    = 0;
      resp_yumi = 1'b0;
      while (!stalled && issued < 8) begin
         cmd.op   = (issued % 2 == 0) ? mem_noc_pkg::e_mem_wr : mem_noc_pkg::e_mem_rd;
         cmd.addr = 16'(32 + issued / 2);
         cmd.data = $urandom;
         issue_cmd(cmd, TXN_CYCLES, ok);
         if (ok) begin
            issued++;
         end else begin
            stalled = 1'b1;
         end
      end
      assert (stalled) else begin
         $display("At %0t mem_cmd_ready_o never went low while responses were held", $time);
         errors++;
      end
      wait_response(seen);
      if (seen) begin
         hold_check(30);
      end
      while (exp_q.size() > 0 && seen) begin
         take_response(0);
         if (exp_q.size() > 0) begin
            wait_response(seen);
         end
      end
   endtask

   task automatic random_mix();
      mem_noc_pkg::mem_msg_s cmd;
      for (int n = 0; n < 200; n++) begin
         cmd.op   = ($urandom_range(0, 1) == 1) ? mem_noc_pkg::e_mem_wr
                                                : mem_noc_pkg::e_mem_rd;
         cmd.addr = 16'($urandom);
         cmd.data = $urandom;
         send_cmd(cmd);
         take_response(int'($urandom_range(0, 4)));
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Run control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      void'($urandom(32'h8304_7407));
      errors    = 0;
      clk       = 1'b0;
      rst_n     = 1'b0;
      cmd_data  = '0;
      cmd_v     = 1'b0;
      resp_yumi = 1'b0;
      my_did    = 2'd1;
      dst_did   = 2'd2;
      my_cord   = 4'h3;
      dst_cord  = 4'h9;
      for (int i = 0; i < STORE_DEPTH; i++) begin
         model_mem[i] = '0;
      end
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      assert (!resp_v) else begin
         $display("[FAIL] %0t mem_resp_v_o got %b expected 0", $time, resp_v);
         errors++;
      end
      assert (cmd_ready) else begin
         $display("[FAIL] %0t mem_cmd_ready_o got %b expected 1", $time, cmd_ready);
         errors++;
      end
      read_after_reset();
      write_then_read();
      address_aliasing();
      response_backpressure();
      random_mix();
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
      $display("Errors: %0d", errors + 1);
      $display("Done: errors found");
      $finish;
   end

endmodule

/* mem_link_top.f */
design/mem_noc_pkg.sv
design/mem_packet_encode.sv
design/wormhole_adapter_in.sv
design/wormhole_adapter_out.sv
design/mem_link_master.sv
design/mem_word_store.sv
design/mem_link_client.sv
design/mem_link_top.sv
tests/mem_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the memory link testbench with Verilator and runs it.
# The run fails when the build fails, the simulator exits badly,
# or the log holds the failure line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
   --top-module mem_link_tb \
   -Mdir obj_dir -o mem_link_sim \
   -f mem_link_top.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/mem_link_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
   exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0
